// File: design/soc_mem_pkg.sv
// Shared memory bus definitions
`default_nettype none

package soc_mem_pkg;

  // --------------------------------------------------
  // Bus geometry
  // --------------------------------------------------

  parameter int DataWidth = 64;             // Bus word width
  parameter int StrbWidth = DataWidth / 8;  // One enable per byte lane

  // Debug and core
  parameter int NumMasters = 2;

  // --------------------------------------------------
  // Word and enable types
  // --------------------------------------------------

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // One storage word, seen either whole or by byte lane.
  // The byte view lets a write touch only the enabled lanes
  // while reads always return the whole word.
  typedef union packed {
    data_t                       word;   // Whole word for reads
    logic [StrbWidth-1:0][7:0]   bytes;  // Lane view for merges
  } mem_word_u;

endpackage

`default_nettype wire

// File: design/mem_ifs.sv
// Master request and memory port interfaces
`default_nettype none

// Four-phase req/ack bus from one master to the arbiter
interface mem_req_if #(
  parameter int AddrWidth = 8
);
  logic                   req;
  logic                   we;
  logic [AddrWidth-1:0]   addr;
  soc_mem_pkg::strb_t     be;
  soc_mem_pkg::data_t     wdata;
  logic                   ack;
  soc_mem_pkg::data_t     rdata;

  modport master  (output req, we, addr, be, wdata, input  ack, rdata);
  modport arbiter (input  req, we, addr, be, wdata, output ack, rdata);
endinterface

// Single-cycle word port from the arbiter to the memory
interface mem_port_if #(
  parameter int AddrWidth = 8
);
  logic                   en;
  logic                   we;
  logic [AddrWidth-1:0]   addr;
  soc_mem_pkg::strb_t     be;
  soc_mem_pkg::data_t     wdata;
  soc_mem_pkg::data_t     rdata;

  modport ctrl (output en, we, addr, be, wdata, input  rdata);
  modport mem  (input  en, we, addr, be, wdata, output rdata);
endinterface

`default_nettype wire

// File: design/rst_sequencer.sv
// Post-reset ready sequencer
`default_nettype none

module rst_sequencer #(
  parameter int RstCountWidth = 6
) (
  input  logic mig_ui_clk,
  input  logic mig_ui_rst,
  input  logic pll_locked_i,
  output logic sys_ready_o
);

  logic [RstCountWidth-1:0] count_q;
  logic                     count_full;
  logic                     ready_q;

  assign count_full = &count_q;  // Saturated at all ones

  // --------------------------------------------------
  // Count and ready flag
  // --------------------------------------------------

  always_ff @(posedge mig_ui_clk or posedge mig_ui_rst)
  begin
    if (mig_ui_rst)
    begin
      count_q <= '0;
      ready_q <= 1'b0;
    end
    else
    begin
      if (!count_full)
        count_q <= count_q + 1'b1;  // Stops once full
      if (count_full && pll_locked_i)
        ready_q <= 1'b1;            // Sticky until next reset
    end
  end

  assign sys_ready_o = ready_q;

  // Once released, the system stays released
  ready_sticky_a: assert property (
    @(posedge mig_ui_clk) disable iff (mig_ui_rst)
    sys_ready_o |=> sys_ready_o
  );

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
// Round-robin arbiter for the shared memory
`default_nettype none

module mem_arbiter #(
  parameter int AddrWidth = 8
) (
  input  logic        mig_ui_clk,
  input  logic        mig_ui_rst,
  input  logic        sys_ready_i,
  mem_req_if.arbiter  dbg_bus,
  mem_req_if.arbiter  core_bus,
  mem_port_if.ctrl    mem
);

  localparam logic [1:0] StIdle    = 2'd0;  // Waiting for a request
  localparam logic [1:0] StAccess  = 2'd1;  // Memory port driven
  localparam logic [1:0] StRespond = 2'd2;  // Ack held until req drops
  localparam logic [1:0] StRelease = 2'd3;  // Ack low, back to idle

  logic [1:0]                          state_q;
  logic [soc_mem_pkg::NumMasters-1:0]  pend;         // Bit 0 debug, bit 1 core
  logic [soc_mem_pkg::NumMasters-1:0]  grant_q;      // One-hot winner
  logic [soc_mem_pkg::NumMasters-1:0]  ack_q;
  logic                                last_core_q;  // Core was served last
  logic                                win_req;
  logic                                sel_core;

  assign pend     = {core_bus.req, dbg_bus.req};
  assign win_req  = |(pend & grant_q);  // Winner still holding req
  assign sel_core = grant_q[1];

  // --------------------------------------------------
  // Grant and handshake FSM
  // --------------------------------------------------

  always_ff @(posedge mig_ui_clk or posedge mig_ui_rst)
  begin
    if (mig_ui_rst)
    begin
      state_q     <= StIdle;
      grant_q     <= '0;
      ack_q       <= '0;
      last_core_q <= 1'b0;  // Debug counts as served last
    end
    else
    begin
      case (state_q)
        StIdle:
        begin
          if (sys_ready_i && (|pend))
          begin
            if (&pend)
              grant_q <= last_core_q ? 2'b01 : 2'b10;  // Tie goes to the other one
            else
              grant_q <= pend;
            state_q <= StAccess;
          end
        end
        StAccess:
        begin
          ack_q       <= grant_q;  // Read data lands on this edge
          last_core_q <= grant_q[1];
          state_q     <= StRespond;
        end
        StRespond:
        begin
          if (!win_req)
          begin
            ack_q   <= '0;
            state_q <= StRelease;
          end
        end
        default:
          state_q <= StIdle;
      endcase
    end
  end

  // --------------------------------------------------
  // Memory port and responses
  // --------------------------------------------------

  assign mem.en    = (state_q == StAccess);
  assign mem.we    = sel_core ? core_bus.we    : dbg_bus.we;
  assign mem.addr  = sel_core ? core_bus.addr  : dbg_bus.addr;
  assign mem.be    = sel_core ? core_bus.be    : dbg_bus.be;
  assign mem.wdata = sel_core ? core_bus.wdata : dbg_bus.wdata;

  // Memory holds its read register until the next access
  assign dbg_bus.rdata  = mem.rdata;
  assign core_bus.rdata = mem.rdata;
  assign dbg_bus.ack    = ack_q[0];
  assign core_bus.ack   = ack_q[1];

  acks_exclusive_a: assert property (
    @(posedge mig_ui_clk) disable iff (mig_ui_rst)
    !(dbg_bus.ack && core_bus.ack)
  );

  // An ack answers a live request, never a stale one
  dbg_ack_on_req_a: assert property (
    @(posedge mig_ui_clk) disable iff (mig_ui_rst)
    $rose(dbg_bus.ack) |-> $past(dbg_bus.req)
  );

  core_ack_on_req_a: assert property (
    @(posedge mig_ui_clk) disable iff (mig_ui_rst)
    $rose(core_bus.ack) |-> $past(core_bus.req)
  );

endmodule

`default_nettype wire

// File: design/sram_bank.sv
// Word memory with byte-lane writes
`default_nettype none

module sram_bank #(
  parameter int AddrWidth = 8
) (
  input  logic     mig_ui_clk,
  mem_port_if.mem  mem
);

  localparam int Depth = 2 ** AddrWidth;  // 256 words by default

  soc_mem_pkg::mem_word_u  ram_q [Depth];
  soc_mem_pkg::mem_word_u  wr_word;
  soc_mem_pkg::data_t      rdata_q;

  // Incoming data seen lane by lane
  assign wr_word.word = mem.wdata;

  // --------------------------------------------------
  // Storage access
  // --------------------------------------------------

  // Reads return the word as it was before this edge's write.
  // The read register only moves on an access, so the
  // arbiter can present it for as long as its ack lasts.
  always_ff @(posedge mig_ui_clk)
  begin
    if (mem.en)
    begin
      if (mem.we)
      begin
        for (int lane = 0; lane < soc_mem_pkg::StrbWidth; lane++)
        begin
          if (mem.be[lane])
            ram_q[mem.addr].bytes[lane] <= wr_word.bytes[lane];  // Enabled lanes only
        end
      end
      rdata_q <= ram_q[mem.addr].word;
    end
  end

  assign mem.rdata = rdata_q;

  port_en_known_a: assert property (
    @(posedge mig_ui_clk)
    !$isunknown(mem.en)
  );

endmodule

`default_nettype wire

// File: design/fan_pwm.sv
// Fan PWM generator
`default_nettype none

module fan_pwm #(
  parameter int PwmWidth = 4
) (
  input  logic                mig_ui_clk,
  input  logic                mig_ui_rst,
  input  logic [PwmWidth-1:0] pwm_setting_i,
  output logic                fan_pwm_o
);

  logic [PwmWidth-1:0] period_q;  // Wraps every 2**PwmWidth cycles
  logic                pwm_q;

  // --------------------------------------------------
  // Period counter and compare
  // --------------------------------------------------

  always_ff @(posedge mig_ui_clk or posedge mig_ui_rst)
  begin
    if (mig_ui_rst)
    begin
      period_q <= '0;
      pwm_q    <= 1'b0;
    end
    else
    begin
      period_q <= period_q + 1'b1;
      pwm_q    <= (period_q < pwm_setting_i);  // High for setting cycles per period
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

`default_nettype wire

// File: design/fpga_soc_top.sv
// FPGA memory subsystem top level
`default_nettype none

module fpga_soc_top #(
  parameter int AddrWidth     = 8,
  parameter int RstCountWidth = 6,
  parameter int PwmWidth      = 4
) (
  input  logic                 mig_ui_clk,
  input  logic                 mig_ui_rst,
  input  logic                 pll_locked_i,
  // Debug master
  input  logic                 dbg_req_i,
  input  logic                 dbg_we_i,
  input  logic [AddrWidth-1:0] dbg_addr_i,
  input  soc_mem_pkg::strb_t   dbg_be_i,
  input  soc_mem_pkg::data_t   dbg_wdata_i,
  output logic                 dbg_ack_o,
  output soc_mem_pkg::data_t   dbg_rdata_o,
  // Core master
  input  logic                 core_req_i,
  input  logic                 core_we_i,
  input  logic [AddrWidth-1:0] core_addr_i,
  input  soc_mem_pkg::strb_t   core_be_i,
  input  soc_mem_pkg::data_t   core_wdata_i,
  output logic                 core_ack_o,
  output soc_mem_pkg::data_t   core_rdata_o,
  // Board
  input  logic [PwmWidth-1:0]  pwm_setting_i,
  output logic                 sys_ready_o,
  output logic                 fan_pwm_o
);

  mem_req_if  #(.AddrWidth(AddrWidth)) dbg_bus ();
  mem_req_if  #(.AddrWidth(AddrWidth)) core_bus ();
  mem_port_if #(.AddrWidth(AddrWidth)) mem_port ();

  logic sys_ready;

  // --------------------------------------------------
  // Master ports onto the request buses
  // --------------------------------------------------

  assign dbg_bus.req    = dbg_req_i;
  assign dbg_bus.we     = dbg_we_i;
  assign dbg_bus.addr   = dbg_addr_i;
  assign dbg_bus.be     = dbg_be_i;
  assign dbg_bus.wdata  = dbg_wdata_i;
  assign dbg_ack_o      = dbg_bus.ack;
  assign dbg_rdata_o    = dbg_bus.rdata;

  assign core_bus.req   = core_req_i;
  assign core_bus.we    = core_we_i;
  assign core_bus.addr  = core_addr_i;
  assign core_bus.be    = core_be_i;
  assign core_bus.wdata = core_wdata_i;
  assign core_ack_o     = core_bus.ack;
  assign core_rdata_o   = core_bus.rdata;

  assign sys_ready_o = sys_ready;

  // --------------------------------------------------
  // Instances
  // --------------------------------------------------

  rst_sequencer #(.RstCountWidth(RstCountWidth)) i_rst_seq (
    .mig_ui_clk   (mig_ui_clk),
    .mig_ui_rst   (mig_ui_rst),
    .pll_locked_i (pll_locked_i),
    .sys_ready_o  (sys_ready)
  );

  mem_arbiter #(.AddrWidth(AddrWidth)) i_arbiter (
    .mig_ui_clk  (mig_ui_clk),
    .mig_ui_rst  (mig_ui_rst),
    .sys_ready_i (sys_ready),  // Holds off all grants until released
    .dbg_bus     (dbg_bus),
    .core_bus    (core_bus),
    .mem         (mem_port)
  );

  sram_bank #(.AddrWidth(AddrWidth)) i_sram (
    .mig_ui_clk (mig_ui_clk),
    .mem        (mem_port)
  );

  fan_pwm #(.PwmWidth(PwmWidth)) i_fan_pwm (
    .mig_ui_clk    (mig_ui_clk),
    .mig_ui_rst    (mig_ui_rst),
    .pwm_setting_i (pwm_setting_i),
    .fan_pwm_o     (fan_pwm_o)
  );

endmodule

`default_nettype wire

// File: verif/tb_mem_table.svh
// Memory access table
`ifndef TB_MEM_TABLE_SVH
`define TB_MEM_TABLE_SVH

localparam int NumRows = 17;

bit                   row_core       [NumRows];  // 0 debug, 1 core
bit                   row_we         [NumRows];
logic [AddrWidth-1:0] row_addr       [NumRows];
soc_mem_pkg::strb_t   row_be         [NumRows];
soc_mem_pkg::data_t   row_wdata      [NumRows];
bit                   row_gen        [NumRows];  // Data and enables drawn at random
bit                   row_pair       [NumRows];  // Issued in the same cycle as the next row
bit                   row_first_core [NumRows];  // Expected first ack of a pair
soc_mem_pkg::data_t   row_exp        [NumRows];  // Filled from the shadow memory

task automatic set_row(input int idx, input bit core, input bit we,
                       input logic [AddrWidth-1:0] addr, input soc_mem_pkg::strb_t be,
                       input soc_mem_pkg::data_t wdata, input bit gen, input bit pair,
                       input bit first_core);
  row_core[idx]       = core;
  row_we[idx]         = we;
  row_addr[idx]       = addr;
  row_be[idx]         = be;
  row_wdata[idx]      = wdata;
  row_gen[idx]        = gen;
  row_pair[idx]       = pair;
  row_first_core[idx] = first_core;
endtask

task automatic load_table();
  int unsigned r;
  //      idx core  we    addr   be     wdata                   gen   pair  first
  set_row( 0, 1'b0, 1'b1, 8'h10, 8'hff, 64'h0123_4567_89ab_cdef, 1'b0, 1'b0, 1'b0);
  set_row( 1, 1'b0, 1'b0, 8'h10, 8'h00, 64'h0,                   1'b0, 1'b0, 1'b0);
  set_row( 2, 1'b1, 1'b1, 8'h20, 8'hff, 64'hdead_beef_cafe_f00d, 1'b0, 1'b0, 1'b0);
  set_row( 3, 1'b1, 1'b1, 8'h20, 8'h00, 64'h0,                   1'b1, 1'b0, 1'b0);
  set_row( 4, 1'b1, 1'b0, 8'h20, 8'h00, 64'h0,                   1'b0, 1'b0, 1'b0);
  set_row( 5, 1'b0, 1'b1, 8'h30, 8'hff, 64'ha5a5_a5a5_0f0f_0f0f, 1'b0, 1'b0, 1'b0);
  set_row( 6, 1'b1, 1'b0, 8'h30, 8'h00, 64'h0,                   1'b0, 1'b0, 1'b0);
  set_row( 7, 1'b1, 1'b1, 8'h31, 8'hff, 64'h5a5a_5a5a_f0f0_f0f0, 1'b0, 1'b0, 1'b0);
  set_row( 8, 1'b0, 1'b0, 8'h31, 8'h00, 64'h0,                   1'b0, 1'b0, 1'b0);
  set_row( 9, 1'b1, 1'b1, 8'h31, 8'h00, 64'h0,                   1'b1, 1'b0, 1'b0);
  set_row(10, 1'b0, 1'b0, 8'h31, 8'h00, 64'h0,                   1'b0, 1'b0, 1'b0);
  set_row(11, 1'b1, 1'b0, 8'h10, 8'h00, 64'h0,                   1'b0, 1'b1, 1'b1);
  set_row(12, 1'b0, 1'b0, 8'h20, 8'h00, 64'h0,                   1'b0, 1'b0, 1'b0);
  set_row(13, 1'b1, 1'b1, 8'h40, 8'hff, 64'h7777_6666_5555_4444, 1'b0, 1'b0, 1'b0);
  set_row(14, 1'b1, 1'b1, 8'h30, 8'h00, 64'h0,                   1'b1, 1'b1, 1'b0);
  set_row(15, 1'b0, 1'b0, 8'h40, 8'h00, 64'h0,                   1'b0, 1'b0, 1'b0);
  set_row(16, 1'b0, 1'b0, 8'h30, 8'h00, 64'h0,                   1'b0, 1'b0, 1'b0);
  for (int i = 0; i < NumRows; i++)
  begin
    if (row_gen[i])
    begin
      r            = $urandom;
      row_be[i]    = {r[7:2], 2'b10};  // Always a partial write
      row_wdata[i] = {$urandom, $urandom};
    end
  end
endtask

`endif

// File: verif/tb_fpga_soc.sv
// Memory subsystem testbench
`default_nettype none

module tb_fpga_soc;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AddrWidth = 8;

  logic                 mig_ui_clk;
  logic                 mig_ui_rst;
  logic                 pll_locked_i;
  logic                 dbg_req_i, dbg_we_i, dbg_ack_o;
  logic [AddrWidth-1:0] dbg_addr_i;
  soc_mem_pkg::strb_t   dbg_be_i;
  soc_mem_pkg::data_t   dbg_wdata_i, dbg_rdata_o;
  logic                 core_req_i, core_we_i, core_ack_o;
  logic [AddrWidth-1:0] core_addr_i;
  soc_mem_pkg::strb_t   core_be_i;
  soc_mem_pkg::data_t   core_wdata_i, core_rdata_o;
  logic [3:0]           pwm_setting_i;
  logic                 sys_ready_o;
  logic                 fan_pwm_o;

  `include "tb_mem_table.svh"

  localparam int CycleLimit = 100 + 12 * NumRows + 64;

  soc_mem_pkg::data_t shadow_mem [2 ** AddrWidth];
  bit                 ack_order [$];  // Master of each ack, in order
  int                 cycle_count = 0;

  fpga_soc_top #(.AddrWidth(AddrWidth)) uut (.*);

  initial
  begin
    mig_ui_clk = 1'b0;
    forever #20 mig_ui_clk = ~mig_ui_clk;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  task automatic report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1, "Stopped at the first failed check");
  endtask

  task automatic next_cycle();
    @(posedge mig_ui_clk);
    #2;  // Drive and sample just after the edge
  endtask

  // Expected data from byte-lane merges in table order
  function automatic void compute_expected();
    for (int i = 0; i < NumRows; i++)
    begin
      if (row_we[i])
        for (int lane = 0; lane < soc_mem_pkg::StrbWidth; lane++)
          if (row_be[i][lane])
            shadow_mem[row_addr[i]][lane*8 +: 8] = row_wdata[i][lane*8 +: 8];
      row_exp[i] = shadow_mem[row_addr[i]];
    end
  endfunction

  task automatic drive_access(input bit core, input bit we, input logic [AddrWidth-1:0] addr,
                              input soc_mem_pkg::strb_t be, input soc_mem_pkg::data_t wdata,
                              output soc_mem_pkg::data_t rdata);
    next_cycle();
    if (core)
    begin
      core_we_i    = we;
      core_addr_i  = addr;
      core_be_i    = be;
      core_wdata_i = wdata;
      core_req_i   = 1'b1;
    end
    else
    begin
      dbg_we_i    = we;
      dbg_addr_i  = addr;
      dbg_be_i    = be;
      dbg_wdata_i = wdata;
      dbg_req_i   = 1'b1;
    end
    do
      next_cycle();
    while (!(core ? core_ack_o : dbg_ack_o));
    ack_order.push_back(core);
    rdata = core ? core_rdata_o : dbg_rdata_o;
    if (core)
      core_req_i = 1'b0;
    else
      dbg_req_i = 1'b0;
    do
      next_cycle();
    while (core ? core_ack_o : dbg_ack_o);  // Four-phase close
  endtask

  task automatic run_row(input int idx);
    soc_mem_pkg::data_t got;
    drive_access(row_core[idx], row_we[idx], row_addr[idx], row_be[idx], row_wdata[idx], got);
    if (!row_we[idx])
      assert (got === row_exp[idx])
      else report_error($sformatf("%s read of 0x%0h returned %h, expected %h",
                                  row_core[idx] ? "core" : "dbg", row_addr[idx], got,
                                  row_exp[idx]));
  endtask

  // Runaway guard and ack exclusivity
  always @(negedge mig_ui_clk)
  begin
    cycle_count++;
    assert (!(dbg_ack_o && core_ack_o))
    else report_error("dbg_ack_o and core_ack_o high in the same cycle");
    if (cycle_count >= CycleLimit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("TEST FAIL");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial
  begin
    int duty [3];
    int highs;
    int waited;
    int i;
    void'($urandom(40));
    mig_ui_rst    = 1'b1;
    pll_locked_i  = 1'b0;
    dbg_req_i     = 1'b0;
    dbg_we_i      = 1'b0;
    dbg_addr_i    = '0;
    dbg_be_i      = '0;
    dbg_wdata_i   = '0;
    core_req_i    = 1'b0;
    core_we_i     = 1'b0;
    core_addr_i   = '0;
    core_be_i     = '0;
    core_wdata_i  = '0;
    pwm_setting_i = '0;
    duty          = '{0, 5, 15};
    load_table();
    compute_expected();
    repeat (5) @(posedge mig_ui_clk);
    #2;
    mig_ui_rst = 1'b0;
    assert (!sys_ready_o && !dbg_ack_o && !core_ack_o && !fan_pwm_o)
    else report_error("outputs not low after reset");

    repeat (80)
    begin
      next_cycle();
      assert (!sys_ready_o) else report_error("sys_ready_o high while the PLL is unlocked");
    end
    pll_locked_i = 1'b1;
    waited       = 0;
    while (!sys_ready_o && waited < 2)
    begin
      next_cycle();
      waited++;
    end
    assert (sys_ready_o) else report_error("sys_ready_o did not rise within 2 cycles of lock");

    i = 0;
    while (i < NumRows)
    begin
      if (row_pair[i])
      begin
        ack_order.delete();
        fork  // Both requests rise in the same cycle
          run_row(i);
          run_row(i + 1);
        join
        assert (ack_order[0] == row_first_core[i])
        else report_error($sformatf("tie at row %0d acked the wrong master first", i));
        i += 2;
      end
      else
      begin
        run_row(i);
        i++;
      end
    end

    for (int k = 0; k < 3; k++)
    begin
      next_cycle();
      pwm_setting_i = duty[k][3:0];
      repeat (2) next_cycle();  // Let the compare pick up the setting
      highs = 0;
      repeat (16)
      begin
        next_cycle();
        if (fan_pwm_o)
          highs++;
      end
      assert (highs == duty[k])
      else report_error($sformatf("fan duty %0d gave %0d high cycles in 16", duty[k], highs));
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verif
design/soc_mem_pkg.sv
design/mem_ifs.sv
design/rst_sequencer.sv
design/mem_arbiter.sv
design/sram_bank.sv
design/fan_pwm.sv
design/fpga_soc_top.sv
verif/tb_fpga_soc.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb_fpga_soc \
  -f verilog.f --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0
